//--- tb.f
logic/camera_app_pkg.sv
logic/msg_fifo_if.sv
logic/msg_fifo.sv
logic/host_msg_router.sv
logic/frame_tracker.sv
logic/coeff_dram_ctrl.sv
logic/camera_app_top.sv
tb/dram_app_model.sv
tb/camera_app_assertions.sv
tb/camera_app_tb.sv

//--- Bender.yml
package:
  name: camera_app

sources:
  - logic/camera_app_pkg.sv
  - logic/msg_fifo_if.sv
  - logic/msg_fifo.sv
  - logic/host_msg_router.sv
  - logic/frame_tracker.sv
  - logic/coeff_dram_ctrl.sv
  - logic/camera_app_top.sv
  - target: simulation
    files:
      - tb/dram_app_model.sv
      - tb/camera_app_assertions.sv
      - tb/camera_app_tb.sv

//--- tb/camera_app_tb.sv
`default_nettype none

module camera_app_tb import camera_app_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_GROUPS = 12;    // last one carries TAG_LAST
  localparam int N_FRAMES = 3;
  localparam int ECHO_WAIT = 2000; // cycles per wait
  localparam int WORD_EST = N_GROUPS * 5 + N_FRAMES * (N_FRAMES + 2) * (N_FRAMES + 4);
  localparam int WATCHDOG_NS = 20 * (3000 + 40 * WORD_EST + 2 * ECHO_WAIT * (N_FRAMES + 2));

  logic      bus_clk, fds_val;
  logic      pc_msg_empty, pc_msg_ack;
  msg_word_t pc_msg;
  logic      app_rdy, app_wdf_rdy, app_rd_data_valid;
  app_data_t app_rd_data, app_wdf_data, fpga_msg;
  logic      app_en, dram_read, app_wdf_wren, app_wdf_end;
  app_addr_t app_addr;
  logic      fpga_msg_valid, error;
  row_t      n_row;
  col_t      l_col;
  frame_t    n_frame;
  logic      stall_cmd, stall_wdf, end_stall, err_run;

  logic [31:0] lfsr_state;
  msg_word_t   host_q [$];       // words still to offer
  app_data_t   exp_beats [64];   // read-back order
  app_data_t   exp_head;
  int          n_beats, rd_pos, echo_cnt, err_cnt;
  int          held_cnt;         // cycles a host word waited on a full queue

  camera_app_top dut_i (.*);

  dram_app_model model_i (.*);

  bind camera_app_top camera_app_assertions chk_i (
    .bus_clk(bus_clk), .fds_val(fds_val), .pc_msg_empty(pc_msg_empty),
    .pc_msg_ack(pc_msg_ack), .app_en(app_en), .dram_read(dram_read),
    .app_wdf_wren(app_wdf_wren), .app_wdf_rdy(app_wdf_rdy), .app_wdf_end(app_wdf_end),
    .fpga_msg_valid(fpga_msg_valid), .error(error), .app_addr(app_addr)
  );

  initial begin
    bus_clk = 1'b0;
    forever #10 bus_clk = ~bus_clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic msg_word_t lfsr_word();
    msg_word_t w;
    for (int i = 0; i < MSG_W; i++) w = {w[MSG_W-2:0], lfsr_bit()};
    return w;
  endfunction

  function automatic msg_word_t pix_word(input logic fv, input logic lv);
    msg_word_t w;
    w = '0;  // tag 00
    w[FVAL_BIT] = fv;
    w[LVAL_BIT] = lv;
    return w;
  endfunction

  // host source and dram stalls, one random draw set per cycle
  always @(posedge bus_clk) begin : host_drive
    logic gap;
    if (!pc_msg_empty && pc_msg_ack && host_q.size() != 0) void'(host_q.pop_front());
    if (!pc_msg_empty && !pc_msg_ack) held_cnt++;  // back-pressure seen
    gap = lfsr_bit() & lfsr_bit();
    stall_cmd <= lfsr_bit() | lfsr_bit();  // long stalls, coeff queue backs up
    stall_wdf <= lfsr_bit() | lfsr_bit();
    if (host_q.size() != 0 && !gap && !fds_val) begin
      pc_msg_empty <= 1'b0;
      pc_msg <= host_q[0];
    end else begin
      pc_msg_empty <= 1'b1;
    end
  end

  assign exp_head = exp_beats[rd_pos];

  always @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      rd_pos <= 0;
      echo_cnt <= 0;
    end else if (fpga_msg_valid) begin
      rd_pos <= (rd_pos == n_beats - 1) ? 0 : rd_pos + 1;  // replay wraps
      echo_cnt <= echo_cnt + 1;
    end
  end

  echo_matches: assert property (@(posedge bus_clk) disable iff (fds_val)
      fpga_msg_valid |-> fpga_msg == exp_head)
    else begin
      err_cnt++;
      $display("** Error @%0t: echo %h, expected %h", $time, $sampled(fpga_msg),
               $sampled(exp_head));
    end

  no_error_flag: assert property (@(posedge bus_clk) disable iff (fds_val)
      !err_run |-> !error)
    else begin
      err_cnt++;
      $display("** Error @%0t: error output high in a run without a stalled end beat",
               $time);
    end

  task automatic check_val(input string what, input longint got, input longint exp);
    assert (got == exp) else begin
      err_cnt++;
      $display("** Error @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic apply_reset(input logic stall_end);
    @(posedge bus_clk);
    fds_val <= 1'b1;
    end_stall <= stall_end;
    host_q.delete();
    repeat (8) @(posedge bus_clk);
    fds_val <= 1'b0;
  endtask

  // frame gap word, then four coefficient words
  task automatic send_group(input logic [1:0] tag);
    msg_word_t w [4];
    host_q.push_back(lfsr_word() & ~32'h3f);  // tag 00 outside a group
    for (int i = 0; i < 4; i++) w[i] = lfsr_word();
    w[0][1:0] = tag;
    for (int i = 0; i < 4; i++) host_q.push_back(w[i]);
    exp_beats[n_beats] = {w[1], w[0]};  // low word first
    exp_beats[n_beats + 1] = {w[3], w[2]};
    n_beats += 2;
  endtask

  task automatic send_frame(input int lines, input int words);
    for (int l = 0; l < lines; l++) begin
      for (int k = 0; k < words; k++) host_q.push_back(pix_word(1'b1, 1'b1));
      host_q.push_back(pix_word(l != lines - 1, 1'b0));  // last line closes frame
    end
  endtask

  task automatic wait_echoes(input int target);
    int n;
    n = 0;
    while (echo_cnt < target && n < ECHO_WAIT) begin
      @(posedge bus_clk);
      n++;
    end
    if (n == ECHO_WAIT) begin
      err_cnt++;
      $display("timed out waiting for read-back beats at %0t", $time);
    end
    repeat (10) @(posedge bus_clk);  // catch extra beats
    check_val("echo count", echo_cnt, target);
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired at %0t, run did not complete", $time);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int n;
    lfsr_state = 32'h5f77_a5b8;
    fds_val = 1'b1;
    pc_msg_empty = 1'b1;
    pc_msg = '0;
    stall_cmd = 1'b0;
    stall_wdf = 1'b0;
    end_stall = 1'b0;
    err_run = 1'b0;
    n_beats = 0;
    err_cnt = 0;
    held_cnt = 0;

    // upload with stalls, then read-back and frame replays
    apply_reset(1'b0);
    for (int g = 0; g < N_GROUPS; g++) send_group(g == N_GROUPS - 1 ? TAG_LAST : 2'b10);
    wait_echoes(n_beats);
    if (held_cnt == 0) begin
      err_cnt++;
      $display("host flow never stopped on a full message queue");
    end
    check_val("write bursts", model_i.wr_addrs.size(), N_GROUPS);
    for (int g = 0; g < N_GROUPS && g < model_i.wr_addrs.size(); g++)
      check_val("burst address", model_i.wr_addrs[g], START_ADDR + ADDR_INC * g);
    check_val("dram_read", dram_read, 1);
    check_val("n_frame before frames", n_frame, 0);
    for (int f = 0; f < N_FRAMES; f++) begin
      send_frame(f + 2, f + 3);
      wait_echoes(n_beats * (f + 2));
      check_val("n_frame", n_frame, f + 1);
      check_val("n_row", n_row, f + 1);          // last line closes the frame
      check_val("l_col", l_col, 2 * (f + 2));    // first lval word opens the line
    end

    // end beat refused, error must latch
    err_run = 1'b1;
    apply_reset(1'b1);
    send_group(2'b10);
    n = 0;
    while (!error && n < ECHO_WAIT) begin
      @(posedge bus_clk);
      n++;
    end
    if (!error) begin
      err_cnt++;
      $display("error output never rose after the stalled end beat");
    end
    repeat (20) @(posedge bus_clk);
    check_val("error held", error, 1);

    $display("checks done: %0d testbench errors, %0d protocol errors",
             err_cnt, dut_i.chk_i.fail_cnt);
    if (err_cnt == 0 && dut_i.chk_i.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/camera_app_assertions.sv
`default_nettype none

module camera_app_assertions import camera_app_pkg::*; (
  input logic      bus_clk,
  input logic      fds_val,
  input logic      pc_msg_empty,
  input logic      pc_msg_ack,
  input logic      app_en,
  input logic      dram_read,
  input logic      app_wdf_wren,
  input logic      app_wdf_rdy,
  input logic      app_wdf_end,
  input logic      fpga_msg_valid,
  input logic      error,
  input app_addr_t app_addr
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // read by the testbench at the end

  ack_has_word: assert property (@(posedge bus_clk) pc_msg_ack |-> !pc_msg_empty)
    else begin fail_cnt++; $error("ack raised with no host word"); end

  // outputs right after reset release
  reset_values: assert property (@(posedge bus_clk) $fell(fds_val) |->
      !app_en && !dram_read && !app_wdf_wren && !fpga_msg_valid && !error &&
      !pc_msg_ack && app_wdf_end && app_addr == START_ADDR)
    else begin fail_cnt++; $error("outputs not idle after reset"); end

  first_beat_no_end: assert property (@(posedge bus_clk) disable iff (fds_val)
      $rose(app_wdf_wren) |-> !app_wdf_end)
    else begin fail_cnt++; $error("end flag on first beat"); end

  second_beat_end: assert property (@(posedge bus_clk) disable iff (fds_val)
      app_wdf_wren && app_wdf_rdy && !app_wdf_end |=> app_wdf_wren && app_wdf_end)
    else begin fail_cnt++; $error("second beat missing its end flag"); end

  burst_done: assert property (@(posedge bus_clk) disable iff (fds_val)
      app_wdf_wren && app_wdf_rdy && app_wdf_end |=> !app_wdf_wren)
    else begin fail_cnt++; $error("write data after burst end"); end

  stall_to_error: assert property (@(posedge bus_clk) disable iff (fds_val)
      app_wdf_wren && app_wdf_end && !app_wdf_rdy |=> error)
    else begin fail_cnt++; $error("stalled end beat without error"); end

  error_sticky: assert property (@(posedge bus_clk) disable iff (fds_val)
      error |=> error)
    else begin fail_cnt++; $error("error dropped"); end

  read_sticky: assert property (@(posedge bus_clk) disable iff (fds_val)
      dram_read |=> dram_read)
    else begin fail_cnt++; $error("dram_read dropped"); end

endmodule

`default_nettype wire

//--- tb/dram_app_model.sv
`default_nettype none

module dram_app_model import camera_app_pkg::*; (
  input  logic      bus_clk,
  input  logic      fds_val,
  input  logic      stall_cmd,   // random command stall
  input  logic      stall_wdf,   // random write data stall
  input  logic      end_stall,   // refuse every end beat
  input  logic      app_en,
  input  logic      dram_read,
  input  app_addr_t app_addr,
  input  logic      app_wdf_wren,
  input  logic      app_wdf_end,
  input  app_data_t app_wdf_data,
  output logic      app_rdy,
  output logic      app_wdf_rdy,
  output logic      app_rd_data_valid,
  output app_data_t app_rd_data
);
  timeunit 1ns;
  timeprecision 100ps;

  app_data_t mem [int];    // keyed by burst address * 2 + beat
  app_data_t rd_q [$];     // beats waiting to go back
  longint    rd_due [$];   // cycle each beat may leave
  app_addr_t wr_addrs [$]; // burst addresses in write order
  app_addr_t wr_base;
  int        beat_n;
  longint    cyc;

  assign app_rdy = !stall_cmd;
  // end beat never stalls unless the error run asks for it
  assign app_wdf_rdy = end_stall ? !(app_wdf_wren && app_wdf_end)
                                 : (!stall_wdf || (app_wdf_wren && app_wdf_end));

  always @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      cyc = 0;
      beat_n = 0;
      rd_q.delete();
      rd_due.delete();
      wr_addrs.delete();
      app_rd_data_valid <= 1'b0;
      app_rd_data <= '0;
    end else begin
      cyc++;
      if (app_en && app_rdy) begin
        if (dram_read) begin
          for (int b = 0; b < 2; b++) begin  // two beats per read burst
            rd_q.push_back(mem.exists(int'(app_addr) * 2 + b) ?
                           mem[int'(app_addr) * 2 + b] : 'x);
            rd_due.push_back(cyc + 2);
          end
        end else begin
          wr_base = app_addr;  // write command, beats follow
          beat_n = 0;
        end
      end
      if (app_wdf_wren && app_wdf_rdy) begin
        mem[int'(wr_base) * 2 + beat_n] = app_wdf_data;
        beat_n++;
        if (app_wdf_end) wr_addrs.push_back(wr_base);  // burst complete
      end
      if (rd_q.size() != 0 && rd_due[0] <= cyc) begin
        app_rd_data_valid <= 1'b1;
        app_rd_data <= rd_q.pop_front();
        void'(rd_due.pop_front());
      end else begin
        app_rd_data_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/camera_app_top.sv
`default_nettype none

module camera_app_top import camera_app_pkg::*; #(
  parameter int FIFO_DEPTH = 16,
  parameter int AFULL_MARGIN = 2
) (
  input  logic      bus_clk,
  input  logic      fds_val,
  // host words
  input  logic      pc_msg_empty,
  input  msg_word_t pc_msg,
  output logic      pc_msg_ack,
  // dram app port
  input  logic      app_rdy,
  input  logic      app_wdf_rdy,
  input  logic      app_rd_data_valid,
  input  app_data_t app_rd_data,
  output logic      app_en,
  output logic      dram_read,
  output logic      app_wdf_wren,
  output logic      app_wdf_end,
  output app_addr_t app_addr,
  output app_data_t app_wdf_data,
  // echo and status
  output logic      fpga_msg_valid,
  output app_data_t fpga_msg,
  output logic      error,
  output row_t      n_row,
  output col_t      l_col,
  output frame_t    n_frame
);

  msg_fifo_if pix_q ();    // router to frame tracker
  msg_fifo_if coeff_q ();  // router to dram ctrl
  logic       frame_end;

  host_msg_router router_i (
    .bus_clk, .fds_val, .pc_msg_empty, .pc_msg, .pc_msg_ack,
    .pix_q (pix_q.writer),
    .coeff_q (coeff_q.writer)
  );

  msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .AFULL_MARGIN(AFULL_MARGIN)) pix_fifo_i (
    .bus_clk, .fds_val,
    .q (pix_q.store)
  );

  msg_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .AFULL_MARGIN(AFULL_MARGIN)) coeff_fifo_i (
    .bus_clk, .fds_val,
    .q (coeff_q.store)
  );

  frame_tracker tracker_i (
    .bus_clk, .fds_val,
    .pix_q (pix_q.reader),
    .frame_end, .n_row, .l_col, .n_frame
  );

  coeff_dram_ctrl dram_ctrl_i (
    .bus_clk, .fds_val,
    .coeff_q (coeff_q.reader),
    .frame_end,
    .app_rdy, .app_wdf_rdy, .app_rd_data_valid, .app_rd_data,
    .app_en, .dram_read, .app_addr,
    .app_wdf_wren, .app_wdf_data, .app_wdf_end,
    .fpga_msg_valid, .fpga_msg, .error
  );

endmodule

`default_nettype wire

//--- logic/coeff_dram_ctrl.sv
`default_nettype none

module coeff_dram_ctrl import camera_app_pkg::*; (
  input  logic        bus_clk,
  input  logic        fds_val,
  msg_fifo_if.reader  coeff_q,
  input  logic        frame_end,
  input  logic        app_rdy,
  input  logic        app_wdf_rdy,
  input  logic        app_rd_data_valid,
  input  app_data_t   app_rd_data,
  output logic        app_en,
  output logic        dram_read,
  output app_addr_t   app_addr,
  output logic        app_wdf_wren,
  output app_data_t   app_wdf_data,
  output logic        app_wdf_end,
  output logic        fpga_msg_valid,
  output app_data_t   fpga_msg,
  output logic        error
);

  localparam int IDX_W = $clog2(WORDS_PER_BURST);
  localparam int BUF_W = WORDS_PER_BURST * MSG_W;  // two beats

  dram_state_e      state;
  logic [IDX_W-1:0] word_idx;   // next slot in burst_buf
  logic [BUF_W-1:0] burst_buf;
  logic [1:0]       grp_tag;    // tag of the group's first word
  app_addr_t        end_addr;   // one past the last written burst
  app_addr_t        last_addr;
  logic             cmd_ok, beat_ok;

  // words only taken while packing
  assign coeff_q.rd_en = !coeff_q.empty && (state == MSG_WAIT);

  assign cmd_ok = app_en && app_rdy;
  assign beat_ok = app_wdf_wren && app_wdf_rdy;
  assign last_addr = end_addr - ADDR_INC;
  assign error = (state == DRAM_ERROR);  // sticky through the state

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state <= MSG_WAIT;
      word_idx <= '0;
      end_addr <= START_ADDR;
      app_addr <= START_ADDR;
      app_en <= 1'b0;
      dram_read <= 1'b0;
      app_wdf_wren <= 1'b0;
      app_wdf_end <= 1'b1;
      fpga_msg_valid <= 1'b0;
    end else begin
      fpga_msg_valid <= app_rd_data_valid;  // echo, one cycle behind
      case (state)
        MSG_WAIT:
          if (coeff_q.rd_en) begin
            if (word_idx == IDX_W'(WORDS_PER_BURST - 1)) begin  // buffer full
              app_en <= 1'b1;
              end_addr <= end_addr + ADDR_INC;
              state <= WR_WAIT;
            end
            word_idx <= word_idx + 1'b1;  // wraps back to slot 0
          end
        WR_WAIT:
          if (cmd_ok) begin
            app_addr <= app_addr + ADDR_INC;  // next write slot
            app_en <= 1'b0;
            app_wdf_wren <= 1'b1;  // first beat
            app_wdf_end <= 1'b0;
            state <= WR1;
          end
        WR1:
          if (beat_ok) begin
            app_wdf_end <= 1'b1;  // second beat closes burst
            state <= WR2;
          end
        WR2: begin
          app_wdf_wren <= 1'b0;
          if (!app_wdf_rdy) state <= DRAM_ERROR;  // end beat stalled
          else if (grp_tag == TAG_LAST) begin
            // upload done, switch to read-back
            app_addr <= START_ADDR;
            dram_read <= 1'b1;
            app_en <= 1'b1;
            state <= READING;
          end else state <= MSG_WAIT;
        end
        READING:
          if (cmd_ok) begin
            if (app_addr == last_addr) begin  // whole region requested
              app_en <= 1'b0;
              state <= INTERFRAME;
            end else app_addr <= app_addr + ADDR_INC;
          end
        INTERFRAME:
          if (frame_end) begin  // replay once per frame
            app_addr <= START_ADDR;
            app_en <= 1'b1;
            state <= READING;
          end
        default: begin  // DRAM_ERROR, hold everything
          app_en <= 1'b0;
          app_wdf_wren <= 1'b0;
        end
      endcase
    end
  end

  // payload path
  always_ff @(posedge bus_clk) begin
    fpga_msg <= app_rd_data;
    if (coeff_q.rd_en) begin
      burst_buf[word_idx*MSG_W +: MSG_W] <= coeff_q.rd_data;  // low word first
      if (word_idx == '0) grp_tag <= coeff_q.rd_data[1:0];
    end
    if (state == WR_WAIT && cmd_ok) app_wdf_data <= burst_buf[0 +: APP_DATA_W];
    else if (state == WR1 && beat_ok) app_wdf_data <= burst_buf[APP_DATA_W +: APP_DATA_W];
  end

endmodule

`default_nettype wire

//--- logic/frame_tracker.sv
`default_nettype none

module frame_tracker import camera_app_pkg::*; (
  input  logic        bus_clk,
  input  logic        fds_val,
  msg_fifo_if.reader  pix_q,
  output logic        frame_end,  // one cycle, frame closed
  output row_t        n_row,
  output col_t        l_col,
  output frame_t      n_frame
);

  frame_state_e state;
  logic         fval, lval;

  // pixel words never stall, drain every cycle
  assign pix_q.rd_en = !pix_q.empty;
  assign fval = pix_q.rd_data[FVAL_BIT];
  assign lval = pix_q.rd_data[LVAL_BIT];

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      state <= FR_STANDBY;
      frame_end <= 1'b0;
      n_row <= '0;
      l_col <= '0;
      n_frame <= '0;
    end else begin
      frame_end <= 1'b0;  // default, pulse only
      if (pix_q.rd_en) begin
        case (state)
          FR_STANDBY:
            if (!fval) begin  // sync up on a frame gap
              n_row <= '0;
              l_col <= '0;
              n_frame <= '0;
              state <= FR_INTERFRAME;
            end
          FR_INTRALINE:
            if (lval) l_col <= l_col + PIXELS_PER_CLK;
            else if (fval) begin  // line done, frame goes on
              n_row <= n_row + 1'b1;
              state <= FR_INTERLINE;
            end else begin        // line and frame done together
              n_frame <= n_frame + 1'b1;
              frame_end <= 1'b1;
              state <= FR_INTERFRAME;
            end
          FR_INTERLINE:
            if (lval) begin
              l_col <= '0;
              state <= FR_INTRALINE;
            end
          FR_INTERFRAME:
            if (lval) begin
              n_row <= '0;
              l_col <= '0;
              state <= FR_INTRALINE;
            end
          default: state <= FR_STANDBY;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/host_msg_router.sv
`default_nettype none

module host_msg_router import camera_app_pkg::*; (
  input  logic        bus_clk,
  input  logic        fds_val,
  input  logic        pc_msg_empty,
  input  msg_word_t   pc_msg,
  output logic        pc_msg_ack,
  msg_fifo_if.writer  pix_q,
  msg_fifo_if.writer  coeff_q
);

  localparam int GRP_W = $clog2(WORDS_PER_BURST);

  logic [GRP_W-1:0] grp_cnt;   // position inside a coeff group
  logic             is_pix;    // class of the word on pc_msg
  logic             pend_d;    // a word was taken last cycle
  logic             is_pix_d;
  msg_word_t        msg_d;

  // take a word whenever one is there and both queues have slack
  assign pc_msg_ack = !pc_msg_empty && !pix_q.almost_full && !coeff_q.almost_full;

  // tag 00 only means pixel between groups
  assign is_pix = (pc_msg[1:0] == TAG_PIXEL) && (grp_cnt == '0);

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      grp_cnt <= '0;
      pend_d <= 1'b0;
      is_pix_d <= 1'b0;
    end else begin
      pend_d <= pc_msg_ack;
      is_pix_d <= is_pix;  // lines up with msg_d
      if (pc_msg_ack && !is_pix) begin
        // first coeff word opens a group, counter walks through it
        if (grp_cnt == GRP_W'(WORDS_PER_BURST - 1)) grp_cnt <= '0;
        else grp_cnt <= grp_cnt + 1'b1;
      end
    end
  end

  // accepted word, written one cycle later
  always_ff @(posedge bus_clk) begin
    if (pc_msg_ack) msg_d <= pc_msg;
  end

  assign pix_q.wr_en = pend_d && is_pix_d;
  assign pix_q.wr_data = msg_d;
  assign coeff_q.wr_en = pend_d && !is_pix_d;
  assign coeff_q.wr_data = msg_d;  // same payload, only one queue enabled

endmodule

`default_nettype wire

//--- logic/msg_fifo.sv
`default_nettype none

module msg_fifo import camera_app_pkg::*; #(
  parameter int FIFO_DEPTH = 16,
  parameter int AFULL_MARGIN = 2   // free entries at which almost_full rises
) (
  input logic        bus_clk,
  input logic        fds_val,
  msg_fifo_if.store  q
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  msg_word_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;  // occupancy
  logic             do_wr, do_rd;

  // pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    ptr_next = (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_wr = q.wr_en && (count != CNT_W'(FIFO_DEPTH));  // full drops the word
  assign do_rd = q.rd_en && (count != '0);

  assign q.rd_data = mem[rd_ptr];  // head word, show-ahead
  assign q.empty = (count == '0);
  assign q.almost_full = (CNT_W'(FIFO_DEPTH) - count) <= CNT_W'(AFULL_MARGIN);

  always_ff @(posedge bus_clk or posedge fds_val) begin
    if (fds_val) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) wr_ptr <= ptr_next(wr_ptr);
      if (do_rd) rd_ptr <= ptr_next(rd_ptr);
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // storage, no reset
  always_ff @(posedge bus_clk) begin
    if (do_wr) mem[wr_ptr] <= q.wr_data;
  end

endmodule

`default_nettype wire

//--- logic/msg_fifo_if.sv
`default_nettype none

// one message queue, writer side and reader side
interface msg_fifo_if import camera_app_pkg::*; ();

  logic      wr_en;
  msg_word_t wr_data;
  logic      almost_full;  // room left for words still in flight
  logic      rd_en;
  msg_word_t rd_data;      // show-ahead, valid while !empty
  logic      empty;

  modport writer (
    output wr_en, wr_data,
    input  almost_full
  );

  modport reader (
    output rd_en,
    input  rd_data, empty
  );

  modport store (
    input  wr_en, wr_data, rd_en,
    output almost_full, rd_data, empty
  );

endinterface

`default_nettype wire

//--- logic/camera_app_pkg.sv
`default_nettype none

package camera_app_pkg;

  localparam int MSG_W = 32;       // host word
  localparam int APP_DATA_W = 64;  // one dram beat
  localparam int ADDR_W = 27;
  localparam int WORDS_PER_BURST = 2 * APP_DATA_W / MSG_W;  // two beats worth of words
  localparam int ROW_W = 12;       // 2064 rows incl dark rows
  localparam int COL_W = 11;       // 2048 cols
  localparam int FRAME_W = 20;

  typedef logic [MSG_W-1:0] msg_word_t;
  typedef logic [APP_DATA_W-1:0] app_data_t;
  typedef logic [ADDR_W-1:0] app_addr_t;
  typedef logic [ROW_W-1:0] row_t;
  typedef logic [COL_W-1:0] col_t;
  typedef logic [FRAME_W-1:0] frame_t;

  localparam app_addr_t START_ADDR = '0;  // base of coeff region
  localparam app_addr_t ADDR_INC = 8;     // BL8, one burst
  localparam col_t PIXELS_PER_CLK = 2;
  localparam logic [1:0] TAG_PIXEL = 2'b00;
  localparam logic [1:0] TAG_LAST = 2'b01;  // last coeff group
  localparam int FVAL_BIT = 5;
  localparam int LVAL_BIT = 4;

  typedef enum logic [2:0] {DRAM_ERROR, MSG_WAIT, WR_WAIT, WR1, WR2, READING,
                            INTERFRAME} dram_state_e;
  typedef enum logic [1:0] {FR_STANDBY, FR_INTRALINE, FR_INTERLINE,
                            FR_INTERFRAME} frame_state_e;

endpackage

`default_nettype wire
